//--- filelist.f
rtl/ntm_trainer_pkg.sv
rtl/ntm_delta_gate.sv
rtl/ntm_gradient_accumulator.sv
rtl/ntm_trainer_controller.sv
rtl/ntm_activation_trainer.sv
+incdir+testbench
testbench/tb_ntm_activation_trainer.sv

//--- rtl/ntm_activation_trainer.sv
// NTM LSTM activation trainer
`timescale 1ns/1ps

module ntm_activation_trainer (
  input  logic                                         CLK,
  input  logic                                         RST,
  input  logic                                         start,
  input  ntm_trainer_pkg::trainer_cfg_t                cfg,
  output logic                                         busy,
  output logic                                         done,
  input  logic                                         x_valid,
  input  logic signed [ntm_trainer_pkg::DATA_WIDTH-1:0] x_data,
  output logic                                         x_ready,
  input  logic                                         gate_valid,
  input  ntm_trainer_pkg::gate_sample_t                gate_data,
  output logic                                         gate_ready,
  output logic                                         out_valid,
  output ntm_trainer_pkg::grad_out_t                   out_data,
  input  logic                                         out_ready
);

  localparam int IW = ntm_trainer_pkg::IDX_WIDTH;

  logic          gate_grant;      // Controller phase grant
  logic          delta_in_ready;
  logic [IW-1:0] gate_row;
  logic          da_valid;
  logic          da_ready;
  logic signed [ntm_trainer_pkg::DATA_WIDTH-1:0] da;
  logic [IW-1:0] da_row;
  logic          row_done;
  logic          rd_valid;
  logic          rd_is_bias;
  logic [IW-1:0] rd_row;
  logic [IW-1:0] rd_col;
  logic          clear;

  // Gate moves only with the grant and room in the pipe
  assign gate_ready = gate_grant && delta_in_ready;

  ntm_trainer_controller u_controller (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .cfg        (cfg),
    .busy       (busy),
    .done       (done),
    .x_valid    (x_valid),
    .x_ready    (x_ready),
    .gate_valid (gate_valid && delta_in_ready),  // Count real transfers only
    .gate_ready (gate_grant),
    .gate_row   (gate_row),
    .row_done   (row_done),
    .rd_valid   (rd_valid),
    .rd_is_bias (rd_is_bias),
    .rd_row     (rd_row),
    .rd_col     (rd_col),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .clear      (clear)
  );

  ntm_delta_gate u_delta (
    .CLK       (CLK),
    .RST       (RST),
    .in_valid  (gate_valid && gate_grant),
    .in_ready  (delta_in_ready),
    .in_sample (gate_data),
    .in_row    (gate_row),
    .da_valid  (da_valid),
    .da_ready  (da_ready),
    .da        (da),
    .da_row    (da_row)
  );

  ntm_gradient_accumulator u_accum (
    .CLK        (CLK),
    .RST        (RST),
    .clear      (clear),
    .size_x     (cfg.size_x),  // Latched on clear
    .x_valid    (x_valid),
    .x_ready    (x_ready),
    .x_data     (x_data),
    .da_valid   (da_valid),
    .da_ready   (da_ready),
    .da         (da),
    .da_row     (da_row),
    .row_done   (row_done),
    .rd_valid   (rd_valid),
    .rd_is_bias (rd_is_bias),
    .rd_row     (rd_row),
    .rd_col     (rd_col),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_ready  (out_ready)
  );

endmodule

//--- rtl/ntm_delta_gate.sv
// Activation gradient pipeline
`timescale 1ns/1ps

module ntm_delta_gate (
  input  logic                                         CLK,
  input  logic                                         RST,
  input  logic                                         in_valid,
  output logic                                         in_ready,
  input  ntm_trainer_pkg::gate_sample_t                in_sample,
  input  logic [ntm_trainer_pkg::IDX_WIDTH-1:0]        in_row,
  output logic                                         da_valid,
  input  logic                                         da_ready,
  output logic signed [ntm_trainer_pkg::DATA_WIDTH-1:0] da,
  output logic [ntm_trainer_pkg::IDX_WIDTH-1:0]        da_row
);

  localparam int DW = ntm_trainer_pkg::DATA_WIDTH;
  localparam int IW = ntm_trainer_pkg::IDX_WIDTH;

  logic          en;        // Common advance
  logic          s1_valid;
  logic          s2_valid;
  logic signed [DW-1:0] s1_a2;  // a*a
  logic signed [DW-1:0] s1_i;
  logic signed [DW-1:0] s1_ds;
  logic signed [DW-1:0] s2_t;   // i*(1-a*a)
  logic signed [DW-1:0] s2_ds;
  logic [IW-1:0] s1_row;
  logic [IW-1:0] s2_row;

  // Whole pipe freezes while the accumulator is busy
  assign en       = da_ready;
  assign in_ready = en;

  //////////////////////////////////////////////////////////////////////
  // Valid bits
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      da_valid <= 1'b0;
    end else if (en) begin
      s1_valid <= in_valid;
      s2_valid <= s1_valid;
      da_valid <= s2_valid;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (en) begin
      // Stage 1
      s1_a2  <= DW'(ntm_trainer_pkg::fx_mul(in_sample.a, in_sample.a));
      s1_i   <= in_sample.i;
      s1_ds  <= in_sample.ds;
      s1_row <= in_row;
      // Stage 2 wraps 1 - a^2 at 16 bits
      s2_t   <= DW'(ntm_trainer_pkg::fx_mul(s1_i, ntm_trainer_pkg::ONE_FIXED - s1_a2));
      s2_ds  <= s1_ds;
      s2_row <= s1_row;
      // Stage 3
      da     <= DW'(ntm_trainer_pkg::fx_mul(s2_ds, s2_t));
      da_row <= s2_row;
    end
  end

  // Sample refused by a stalled pipe is held upstream until taken
  assert property (@(posedge CLK) disable iff (RST)
    (in_valid && !in_ready) |=> (in_valid && $stable(in_sample) && $stable(in_row)));

endmodule

//--- rtl/ntm_gradient_accumulator.sv
// dW and db accumulation memories
`timescale 1ns/1ps

module ntm_gradient_accumulator (
  input  logic                                         CLK,
  input  logic                                         RST,
  input  logic                                         clear,
  input  logic [ntm_trainer_pkg::SIZE_WIDTH-1:0]       size_x,
  input  logic                                         x_valid,
  input  logic                                         x_ready,
  input  logic signed [ntm_trainer_pkg::DATA_WIDTH-1:0] x_data,
  input  logic                                         da_valid,
  output logic                                         da_ready,
  input  logic signed [ntm_trainer_pkg::DATA_WIDTH-1:0] da,
  input  logic [ntm_trainer_pkg::IDX_WIDTH-1:0]        da_row,
  output logic                                         row_done,
  input  logic                                         rd_valid,
  input  logic                                         rd_is_bias,
  input  logic [ntm_trainer_pkg::IDX_WIDTH-1:0]        rd_row,
  input  logic [ntm_trainer_pkg::IDX_WIDTH-1:0]        rd_col,
  output logic                                         out_valid,
  output ntm_trainer_pkg::grad_out_t                   out_data,
  input  logic                                         out_ready
);

  localparam int DW    = ntm_trainer_pkg::DATA_WIDTH;
  localparam int AW    = ntm_trainer_pkg::ACC_WIDTH;
  localparam int IW    = ntm_trainer_pkg::IDX_WIDTH;
  localparam int DEPTH = ntm_trainer_pkg::MAX_L * ntm_trainer_pkg::MAX_X;

  logic signed [DW-1:0] x_buf  [ntm_trainer_pkg::MAX_X];  // Current x(t)
  logic signed [AW-1:0] dw_mem [DEPTH];                   // Indexed by row l and column x
  logic signed [AW-1:0] db_mem [ntm_trainer_pkg::MAX_L];
  logic [ntm_trainer_pkg::SIZE_WIDTH-1:0] size_x_q;
  logic [IW-1:0]        last_col;
  logic [IW-1:0]        x_wr_idx;
  logic [IW-1:0]        col;       // Column being added
  logic                 busy_row;
  logic signed [DW-1:0] cur_da;
  logic [IW-1:0]        cur_row;
  logic                 out_load;  // Output register free or draining

  assign last_col = IW'(size_x_q - 1'b1);
  assign da_ready = !busy_row;
  assign row_done = busy_row && (col == last_col);
  assign out_load = !out_valid || out_ready;

  // clear coincides with the cfg sample
  always_ff @(posedge CLK) begin
    if (clear) size_x_q <= size_x;
  end

  //////////////////////////////////////////////////////////////////////
  // x buffer
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) x_wr_idx <= '0;
    else if (clear) x_wr_idx <= '0;
    else if (x_valid && x_ready) x_wr_idx <= (x_wr_idx == last_col) ? '0 : x_wr_idx + 1'b1;
  end

  always_ff @(posedge CLK) begin
    if (x_valid && x_ready) x_buf[x_wr_idx] <= x_data;
  end

  //////////////////////////////////////////////////////////////////////
  // Row walk at one column per cycle
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy_row <= 1'b0;
      col      <= '0;
    end else if (da_valid && da_ready) begin
      busy_row <= 1'b1;
      col      <= '0;
    end else if (busy_row) begin
      busy_row <= !row_done;                 // Drop after last column
      col      <= row_done ? '0 : col + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (da_valid && da_ready) begin
      cur_da  <= da;
      cur_row <= da_row;
    end
  end

  always_ff @(posedge CLK) begin
    if (clear) begin
      for (int k = 0; k < DEPTH; k++) dw_mem[k] <= '0;
      for (int k = 0; k < ntm_trainer_pkg::MAX_L; k++) db_mem[k] <= '0;
    end else if (busy_row) begin
      dw_mem[{cur_row, col}] <= dw_mem[{cur_row, col}] +
                                ntm_trainer_pkg::fx_mul(cur_da, x_buf[col]);
      if (col == '0) db_mem[cur_row] <= db_mem[cur_row] + AW'(cur_da);  // Once per da
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Readout register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) out_valid <= 1'b0;
    else if (out_load) out_valid <= rd_valid;
  end

  always_ff @(posedge CLK) begin
    if (out_load && rd_valid) begin
      out_data.is_bias <= rd_is_bias;
      out_data.row     <= rd_row;
      out_data.col     <= rd_col;
      out_data.value   <= rd_is_bias ? db_mem[rd_row] : dw_mem[{rd_row, rd_col}];
    end
  end

  // Row walk reads x(t) so the next x vector waits for it
  assert property (@(posedge CLK) disable iff (RST)
    busy_row |-> !(x_valid && x_ready));

endmodule

//--- rtl/ntm_trainer_controller.sv
// NTM trainer step and phase control
`timescale 1ns/1ps

module ntm_trainer_controller (
  input  logic                                  CLK,
  input  logic                                  RST,
  input  logic                                  start,
  input  ntm_trainer_pkg::trainer_cfg_t         cfg,
  output logic                                  busy,
  output logic                                  done,
  input  logic                                  x_valid,
  output logic                                  x_ready,
  input  logic                                  gate_valid,
  output logic                                  gate_ready,
  output logic [ntm_trainer_pkg::IDX_WIDTH-1:0] gate_row,
  input  logic                                  row_done,
  output logic                                  rd_valid,
  output logic                                  rd_is_bias,
  output logic [ntm_trainer_pkg::IDX_WIDTH-1:0] rd_row,
  output logic [ntm_trainer_pkg::IDX_WIDTH-1:0] rd_col,
  input  logic                                  out_valid,
  input  logic                                  out_ready,
  output logic                                  clear
);

  localparam int IW = ntm_trainer_pkg::IDX_WIDTH;

  ntm_trainer_pkg::trainer_cfg_t   cfg_q;
  ntm_trainer_pkg::trainer_state_t state;
  logic [IW-1:0] x_cnt;
  logic [IW-1:0] gate_cnt;
  logic [ntm_trainer_pkg::SIZE_WIDTH-1:0] rows_cnt;  // Rows finished this step
  logic [ntm_trainer_pkg::STEP_WIDTH-1:0] step_cnt;
  logic          rd_issued;  // Last readout request sent
  logic [IW-1:0] last_x;
  logic [IW-1:0] last_l;
  logic          start_ok;
  logic          x_fire;
  logic          gate_fire;
  logic          rd_fire;

  assign last_x     = IW'(cfg_q.size_x - 1'b1);
  assign last_l     = IW'(cfg_q.size_l - 1'b1);
  assign busy       = (state != ntm_trainer_pkg::IDLE);
  assign done       = (state == ntm_trainer_pkg::DONE);
  assign start_ok   = start && !busy;
  assign clear      = start_ok;  // Wipe accumulators with cfg sample
  assign x_ready    = (state == ntm_trainer_pkg::LOAD_X);
  assign gate_ready = (state == ntm_trainer_pkg::LOAD_GATES);
  assign gate_row   = gate_cnt;  // Gates arrive in unit order
  assign rd_valid   = (state == ntm_trainer_pkg::OUTPUT) && !rd_issued;
  assign x_fire     = x_valid && x_ready;
  assign gate_fire  = gate_valid && gate_ready;
  assign rd_fire    = rd_valid && (!out_valid || out_ready);  // Address frozen on stall

  always_ff @(posedge CLK) begin
    if (start_ok) cfg_q <= cfg;
  end

  //////////////////////////////////////////////////////////////////////
  // Phase FSM and counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= ntm_trainer_pkg::IDLE;
      x_cnt      <= '0;
      gate_cnt   <= '0;
      rows_cnt   <= '0;
      step_cnt   <= '0;
      rd_is_bias <= 1'b0;
      rd_row     <= '0;
      rd_col     <= '0;
      rd_issued  <= 1'b0;
    end else begin
      if (row_done) rows_cnt <= rows_cnt + 1'b1;  // Any phase of the step
      case (state)
        ntm_trainer_pkg::IDLE: begin
          if (start_ok) begin
            state      <= ntm_trainer_pkg::LOAD_X;
            x_cnt      <= '0;
            gate_cnt   <= '0;
            rows_cnt   <= '0;
            step_cnt   <= '0;
            rd_is_bias <= 1'b0;
            rd_row     <= '0;
            rd_col     <= '0;
            rd_issued  <= 1'b0;
          end
        end
        ntm_trainer_pkg::LOAD_X: begin
          if (x_fire) begin
            x_cnt <= (x_cnt == last_x) ? '0 : x_cnt + 1'b1;
            if (x_cnt == last_x) state <= ntm_trainer_pkg::LOAD_GATES;
          end
        end
        ntm_trainer_pkg::LOAD_GATES: begin
          if (gate_fire) begin
            gate_cnt <= (gate_cnt == last_l) ? '0 : gate_cnt + 1'b1;
            if (gate_cnt == last_l) state <= ntm_trainer_pkg::DRAIN;
          end
        end
        ntm_trainer_pkg::DRAIN: begin
          if (rows_cnt == cfg_q.size_l) begin  // Every da of the step added
            rows_cnt <= '0;
            if (step_cnt == cfg_q.length_t - 1'b1) begin
              step_cnt <= '0;
              state    <= ntm_trainer_pkg::OUTPUT;
            end else begin
              step_cnt <= step_cnt + 1'b1;
              state    <= ntm_trainer_pkg::LOAD_X;
            end
          end
        end
        ntm_trainer_pkg::OUTPUT: begin
          // dW row major, then db
          if (rd_fire) begin
            if (rd_is_bias) begin
              if (rd_row == last_l) rd_issued <= 1'b1;
              else rd_row <= rd_row + 1'b1;
            end else if (rd_col == last_x) begin
              rd_col     <= '0;
              rd_row     <= (rd_row == last_l) ? '0 : rd_row + 1'b1;
              rd_is_bias <= (rd_row == last_l);
            end else begin
              rd_col <= rd_col + 1'b1;
            end
          end
          // Register holds the final word once all requests are out
          if (rd_issued && out_valid && out_ready) state <= ntm_trainer_pkg::DONE;
        end
        ntm_trainer_pkg::DONE: state <= ntm_trainer_pkg::IDLE;  // One-cycle pulse
        default: state <= ntm_trainer_pkg::IDLE;
      endcase
    end
  end

  // Host waits for done before restarting
  assert property (@(posedge CLK) disable iff (RST) start |-> !busy);

  // Empty runs are not supported
  assert property (@(posedge CLK) disable iff (RST)
    start_ok |-> (cfg.size_x != '0) && (cfg.size_l != '0) && (cfg.length_t != '0));

endmodule

//--- rtl/ntm_trainer_pkg.sv
// NTM trainer shared definitions
package ntm_trainer_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and limits
  //////////////////////////////////////////////////////////////////////

  localparam int DATA_WIDTH = 16;  // Q4.12 element
  localparam int FRAC_BITS  = 12;
  localparam int ACC_WIDTH  = 32;  // Gradient accumulators
  localparam int MAX_L      = 8;   // Hidden units
  localparam int MAX_X      = 8;   // Input elements
  localparam int IDX_WIDTH  = 3;
  localparam int SIZE_WIDTH = 4;   // Holds 1 to 8
  localparam int STEP_WIDTH = 8;

  localparam logic signed [DATA_WIDTH-1:0] ONE_FIXED = 16'sh1000;  // 1.0

  //////////////////////////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////////////////////////

  // Run configuration, sampled on start
  typedef struct packed {
    logic [SIZE_WIDTH-1:0] size_x;
    logic [SIZE_WIDTH-1:0] size_l;
    logic [STEP_WIDTH-1:0] length_t;
  } trainer_cfg_t;

  // One hidden unit per time step
  typedef struct packed {
    logic signed [DATA_WIDTH-1:0] a;   // Activation
    logic signed [DATA_WIDTH-1:0] i;   // Input gate
    logic signed [DATA_WIDTH-1:0] ds;  // State gradient
  } gate_sample_t;

  // Streamed gradient word
  typedef struct packed {
    logic                        is_bias;  // db entry, else dW
    logic [IDX_WIDTH-1:0]        row;      // Hidden unit l
    logic [IDX_WIDTH-1:0]        col;      // Input index x
    logic signed [ACC_WIDTH-1:0] value;
  } grad_out_t;

  typedef enum logic [2:0] {
    IDLE,
    LOAD_X,
    LOAD_GATES,
    DRAIN,
    OUTPUT,
    DONE
  } trainer_state_t;

  // Full signed product, arithmetic shift back to Q4.12 scale
  // Caller truncates to its own width
  function automatic logic signed [ACC_WIDTH-1:0] fx_mul(
    input logic signed [DATA_WIDTH-1:0] lhs,
    input logic signed [DATA_WIDTH-1:0] rhs
  );
    logic signed [2*DATA_WIDTH-1:0] prod;
    prod = lhs * rhs;
    return ACC_WIDTH'(prod >>> FRAC_BITS);
  endfunction

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the activation trainer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
  --top-module tb_ntm_activation_trainer \
  -f filelist.f -o tb_ntm_activation_trainer
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_output=$(./obj_dir/tb_ntm_activation_trainer)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -q "All tests passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- testbench/tb_ntm_reference.svh
// Trainer reference model
`ifndef TB_NTM_REFERENCE_SVH
`define TB_NTM_REFERENCE_SVH

localparam logic [31:0] LCG_SEED = 32'h33c1284b;

// 32-bit LCG, modulus 2^32
function automatic logic [31:0] lcg_next(inout logic [31:0] st);
  st = st * 32'd1664525 + 32'd1013904223;
  return st;
endfunction

// Upper half only, low LCG bits cycle fast
function automatic int rand_below(inout logic [31:0] st, input int n);
  logic [31:0] r;
  r = lcg_next(st);
  return int'(r[31:16]) % n;
endfunction

// Signed word, shift sets the range
function automatic logic signed [15:0] rand_fixed(inout logic [31:0] st, input int shift);
  logic [31:0] r;
  r = lcg_next(st);
  return $signed(r[31:16]) >>> shift;
endfunction

// Q4.12 product, full 32-bit result shifted back
function automatic logic signed [31:0] q_mul(input logic signed [15:0] lhs,
                                             input logic signed [15:0] rhs);
  logic signed [31:0] full;
  full = lhs * rhs;
  return full >>> ntm_trainer_pkg::FRAC_BITS;
endfunction

// da = ds * (i * (1 - a*a)), every term wraps at 16 bits
function automatic logic signed [15:0] ref_delta(input ntm_trainer_pkg::gate_sample_t g);
  logic signed [15:0] a_sq;
  logic signed [15:0] one_minus;
  logic signed [15:0] scaled;
  a_sq      = 16'(q_mul(g.a, g.a));
  one_minus = ntm_trainer_pkg::ONE_FIXED - a_sq;
  scaled    = 16'(q_mul(g.i, one_minus));
  return 16'(q_mul(g.ds, scaled));
endfunction

// Expected dW and db over all steps of the stored run
function automatic void compute_expected();
  logic signed [15:0] d;
  for (int l = 0; l < 8; l++) begin
    exp_db[l] = '0;
    for (int k = 0; k < 8; k++) exp_dw[l][k] = '0;
  end
  for (int t = 0; t < cur_lt; t++) begin
    for (int l = 0; l < cur_sl; l++) begin
      d = ref_delta(gate_stim[t][l]);
      exp_db[l] = exp_db[l] + 32'(d);  // Sign-extended
      for (int k = 0; k < cur_sx; k++) exp_dw[l][k] = exp_dw[l][k] + q_mul(d, x_stim[t][k]);
    end
  end
endfunction

// Word at stream position pos, dW row major then db
function automatic ntm_trainer_pkg::grad_out_t expected_word(input int pos);
  ntm_trainer_pkg::grad_out_t w;
  int dw_words;
  int r;
  int c;
  dw_words = cur_sl * cur_sx;
  r = (pos < dw_words) ? pos / cur_sx : pos - dw_words;
  c = (pos < dw_words) ? pos % cur_sx : 0;
  w.is_bias = (pos >= dw_words);
  w.row     = r[2:0];
  w.col     = c[2:0];
  w.value   = w.is_bias ? exp_db[r] : exp_dw[r][c];
  return w;
endfunction

`endif

//--- testbench/tb_ntm_activation_trainer.sv
// Activation trainer testbench
`timescale 1ns/1ps

module tb_ntm_activation_trainer;

  localparam int MAX_T      = 4;     // Steps per run
  localparam int WAIT_LIMIT = 4000;  // Cycles per handshake

  logic CLK;
  logic RST;
  logic start;
  ntm_trainer_pkg::trainer_cfg_t cfg;
  logic busy;
  logic done;
  logic x_valid;
  logic signed [ntm_trainer_pkg::DATA_WIDTH-1:0] x_data;
  logic x_ready;
  logic gate_valid;
  ntm_trainer_pkg::gate_sample_t gate_data;
  logic gate_ready;
  logic out_valid;
  ntm_trainer_pkg::grad_out_t out_data;
  logic out_ready;

  logic signed [15:0] x_stim [MAX_T][8];            // Step t, element x
  ntm_trainer_pkg::gate_sample_t gate_stim [MAX_T][8];
  logic signed [31:0] exp_dw [8][8];                // Row l, column x
  logic signed [31:0] exp_db [8];
  int cur_sx;
  int cur_sl;
  int cur_lt;
  logic [31:0] stim_seed;
  logic [31:0] ready_seed;  // Own stream for out_ready
  int stall_pct;            // Chance of out_ready low
  int out_pos;              // Next expected word
  int exp_total;
  int done_count;
  int check_count;
  int error_count;
  int test_count;
  int failed_tests;
  bit aborted;              // Any timeout

  `include "tb_ntm_reference.svh"

  ntm_activation_trainer u_dut (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .cfg        (cfg),
    .busy       (busy),
    .done       (done),
    .x_valid    (x_valid),
    .x_data     (x_data),
    .x_ready    (x_ready),
    .gate_valid (gate_valid),
    .gate_data  (gate_data),
    .gate_ready (gate_ready),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_ready  (out_ready)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  //////////////////////////////////////////////////////////////////////
  // Output checker, out_ready owner
  //////////////////////////////////////////////////////////////////////

  // Outputs are steady from here to the next rising edge
  initial begin : output_checker
    ntm_trainer_pkg::grad_out_t want;
    forever begin
      @(negedge CLK);
      if (done) done_count++;
      out_ready = RST ? 1'b0 : (rand_below(ready_seed, 100) >= stall_pct);
      if (out_valid && out_ready) begin  // Transfer on the coming edge
        assert (out_pos < exp_total) else begin
          $display("Output word %0d arrived after the last expected word", out_pos);
          error_count++;
        end
        if (out_pos < exp_total) begin
          want = expected_word(out_pos);
          assert (out_data == want) else begin
            $display("Error: out_data word %0d got %h expected %h", out_pos, out_data, want);
            error_count++;
          end
          check_count++;
        end
        out_pos++;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic idle_gap(input int gap_pct);
    int idle;
    idle = 0;
    if (gap_pct > 0 && rand_below(stim_seed, 100) < gap_pct) idle = 1 + rand_below(stim_seed, 3);
    repeat (idle) @(negedge CLK);
  endtask

  task automatic send_x(input logic signed [15:0] val, input int gap_pct);
    int waited;
    if (aborted) return;
    idle_gap(gap_pct);
    x_valid = 1'b1;
    x_data  = val;
    waited  = 0;
    while (!x_ready && waited < WAIT_LIMIT) begin
      @(negedge CLK);
      waited++;
    end
    assert (x_ready) else begin
      $display("Timeout, x_ready stayed low for %0d cycles", WAIT_LIMIT);
      error_count++;
      aborted = 1'b1;
    end
    if (x_ready) @(negedge CLK);  // Taken on the edge in between
    x_valid = 1'b0;
  endtask

  task automatic send_gate(input ntm_trainer_pkg::gate_sample_t g, input int gap_pct);
    int waited;
    if (aborted) return;
    idle_gap(gap_pct);
    gate_valid = 1'b1;
    gate_data  = g;
    waited     = 0;
    while (!gate_ready && waited < WAIT_LIMIT) begin
      @(negedge CLK);
      waited++;
    end
    assert (gate_ready) else begin
      $display("Timeout, gate_ready stayed low for %0d cycles", WAIT_LIMIT);
      error_count++;
      aborted = 1'b1;
    end
    if (gate_ready) @(negedge CLK);
    gate_valid = 1'b0;
  endtask

  function automatic void fill_random(input int sx, input int sl, input int lt);
    cur_sx = sx;
    cur_sl = sl;
    cur_lt = lt;
    for (int t = 0; t < lt; t++) begin
      for (int k = 0; k < sx; k++) x_stim[t][k] = rand_fixed(stim_seed, 2);  // About +-2.0
      for (int l = 0; l < sl; l++) begin
        gate_stim[t][l].a  = rand_fixed(stim_seed, 3);                // About +-1.0
        gate_stim[t][l].i  = rand_fixed(stim_seed, 4) + 16'sh0800;    // 0 to 1.0
        gate_stim[t][l].ds = rand_fixed(stim_seed, 1);
      end
    end
  endfunction

  // Whole run: start, all steps, then wait for done
  task automatic run_trainer(input int gap_pct);
    int waited;
    if (aborted) return;
    compute_expected();
    exp_total  = cur_sl * cur_sx + cur_sl;
    out_pos    = 0;
    done_count = 0;
    start        = 1'b1;
    cfg.size_x   = cur_sx[3:0];
    cfg.size_l   = cur_sl[3:0];
    cfg.length_t = cur_lt[7:0];
    @(negedge CLK);
    start = 1'b0;
    assert (busy) else begin
      $display("Error: busy got %h expected 1 after start", busy);
      error_count++;
    end
    for (int t = 0; t < cur_lt; t++) begin
      for (int k = 0; k < cur_sx; k++) send_x(x_stim[t][k], gap_pct);
      for (int l = 0; l < cur_sl; l++) send_gate(gate_stim[t][l], gap_pct);
    end
    if (aborted) return;
    waited = 0;
    while (!done && waited < WAIT_LIMIT) begin
      @(negedge CLK);
      waited++;
    end
    assert (done) else begin
      $display("Timeout, done never pulsed within %0d cycles", WAIT_LIMIT);
      error_count++;
      aborted = 1'b1;
    end
    if (aborted) return;
    @(negedge CLK);
    assert (out_pos == exp_total) else begin
      $display("Error: output count got %h expected %h", out_pos, exp_total);
      error_count++;
    end
    assert (done_count == 1 && !busy) else begin
      $display("Error: done pulses got %h expected 1, busy %h", done_count, busy);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_count++;
    if (error_count == errs_before) begin
      $display("Test %0d %s: ok", test_count, name);
    end else begin
      $display("Test %0d %s: FAILED, %0d errors", test_count, name, error_count - errs_before);
      failed_tests++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  initial begin
    int errs;
    int sx;
    int sl;
    RST = 1'b1;
    start = 1'b0;
    cfg = '0;
    x_valid = 1'b0;
    x_data = '0;
    gate_valid = 1'b0;
    gate_data = '0;
    out_ready = 1'b0;
    stim_seed = LCG_SEED;
    ready_seed = LCG_SEED;
    stall_pct = 0;
    out_pos = 0;
    exp_total = 0;
    done_count = 0;
    check_count = 0;
    error_count = 0;
    test_count = 0;
    failed_tests = 0;
    aborted = 1'b0;
    repeat (10) @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);

    errs = error_count;
    assert (!busy && !done && !x_ready && !gate_ready && !out_valid) else begin
      $display("Error: after reset busy=%h done=%h x_ready=%h gate_ready=%h out_valid=%h",
               busy, done, x_ready, gate_ready, out_valid);
      error_count++;
    end
    report_test("reset state", errs);

    // a = 0, i = ds = 1.0 so da is 1.0 and dW copies x
    errs = error_count;
    cur_sx = 2;
    cur_sl = 2;
    cur_lt = 1;
    x_stim[0][0] = 16'sh1800;
    x_stim[0][1] = -16'sh0400;
    for (int l = 0; l < 2; l++) begin
      gate_stim[0][l].a  = '0;
      gate_stim[0][l].i  = ntm_trainer_pkg::ONE_FIXED;
      gate_stim[0][l].ds = ntm_trainer_pkg::ONE_FIXED;
    end
    run_trainer(0);
    for (int l = 0; l < 2; l++) begin
      for (int k = 0; k < 2; k++) begin
        assert (exp_dw[l][k] == 32'(x_stim[0][k])) else begin
          $display("Error: exp_dw got %h expected %h", exp_dw[l][k], 32'(x_stim[0][k]));
          error_count++;
        end
      end
      assert (exp_db[l] == 32'(ntm_trainer_pkg::ONE_FIXED)) else begin
        $display("Error: exp_db got %h expected %h", exp_db[l], 32'(ntm_trainer_pkg::ONE_FIXED));
        error_count++;
      end
    end
    report_test("unit gradient", errs);

    errs = error_count;
    sx = 1 + rand_below(stim_seed, 8);
    sl = 1 + rand_below(stim_seed, 8);
    fill_random(sx, sl, 4);
    run_trainer(0);
    report_test("random four steps", errs);

    errs = error_count;
    stall_pct = 50;
    sx = 1 + rand_below(stim_seed, 8);
    sl = 1 + rand_below(stim_seed, 8);
    fill_random(sx, sl, 3);
    run_trainer(0);
    stall_pct = 0;
    report_test("output back-pressure", errs);

    // Full size so stale entries would show in the next run
    errs = error_count;
    fill_random(8, 8, 4);
    run_trainer(40);
    report_test("input gaps", errs);

    errs = error_count;
    sx = 1 + rand_below(stim_seed, 8);
    sl = 1 + rand_below(stim_seed, 8);
    fill_random(sx, sl, 2);
    run_trainer(0);
    report_test("back-to-back run", errs);

    $display("Tests run %0d, failed %0d, words checked %0d, errors %0d",
             test_count, failed_tests, check_count, error_count);
    if (error_count == 0 && !aborted) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
